/* include/div_config.svh */
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// Operand width of dividend, divisor, quotient and remainder
`define DIV_WIDTH 32

// Step counter width, must be able to hold the value DIV_WIDTH
`define DIV_COUNT_WIDTH 6

`endif

/* verilog/div_pkg.sv */
`include "div_config.svh"

package div_pkg;

    // One operand, quotient or remainder
    typedef logic [`DIV_WIDTH-1:0] div_data_t;

    // Remainder in the upper half, quotient in the lower half
    typedef logic [2*`DIV_WIDTH-1:0] div_result_t;

    // Number of shift-and-subtract steps taken so far
    typedef logic [`DIV_COUNT_WIDTH-1:0] div_count_t;

    // Divider sequencing states
    typedef enum logic [1:0] {
        DIV_IDLE    = 2'b00,
        DIV_BY_ZERO = 2'b01,
        DIV_RUN     = 2'b10,
        DIV_DONE    = 2'b11
    } div_state_e;

endpackage

/* verilog/div_ctrl_fsm.sv */
`timescale 1ns/1ps
`include "div_config.svh"

module div_ctrl_fsm (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               start_i,
    input  logic               cancel_i,
    input  div_pkg::div_data_t divisor_i,
    output logic               load_o,
    output logic               step_o,
    output logic               clear_o,
    output logic               ready_o
);
    import div_pkg::*;

    // Counter value seen during the final step
    localparam div_count_t LAST_STEP = div_count_t'(`DIV_WIDTH - 1);

    div_state_e state_q;
    div_state_e state_d;
    div_count_t count_q;
    logic       divisor_zero;
    logic       accept;
    logic       last_step;

    assign divisor_zero = (divisor_i == '0);
    assign accept       = (state_q == DIV_IDLE) && start_i;
    assign last_step    = (count_q == LAST_STEP);

    // Operands are captured on the same edge that accepts the request
    assign load_o  = accept && !divisor_zero;
    assign clear_o = accept && divisor_zero;
    assign step_o  = (state_q == DIV_RUN);
    assign ready_o = (state_q == DIV_DONE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            DIV_IDLE: begin
                if (start_i) begin
                    state_d = divisor_zero ? DIV_BY_ZERO : DIV_RUN;
                end
            end
            DIV_BY_ZERO: begin
                // Result is already zero, one cycle to present it
                state_d = cancel_i ? DIV_IDLE : DIV_DONE;
            end
            DIV_RUN: begin
                if (cancel_i) begin
                    state_d = DIV_IDLE;
                end else if (last_step) begin
                    state_d = DIV_DONE;
                end
            end
            DIV_DONE: begin
                // Hold the result until the requester lets go of start
                if (!start_i) begin
                    state_d = DIV_IDLE;
                end
            end
            default: begin
                state_d = DIV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= DIV_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Step counter, restarted by every load
    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (load_o) begin
            count_q <= '0;
        end else if (step_o) begin
            count_q <= count_q + div_count_t'(1);
        end
    end

    // A result is never flagged while a step is still in progress
    a_step_ready_excl: assert property (
        @(posedge clk) disable iff (reset_i) !(step_o && ready_o)
    ) else $error("div_ctrl_fsm: step_o and ready_o high together");

    a_count_range: assert property (
        @(posedge clk) disable iff (reset_i) count_q <= div_count_t'(`DIV_WIDTH)
    ) else $error("div_ctrl_fsm: step counter ran past the operand width");

endmodule

/* verilog/div_sign_fix.sv */
`timescale 1ns/1ps
`include "div_config.svh"

module div_sign_fix (
    input  logic                 signed_i,
    input  div_pkg::div_data_t   dividend_i,
    input  div_pkg::div_data_t   divisor_i,
    input  div_pkg::div_data_t   raw_quotient_i,
    input  div_pkg::div_data_t   raw_remainder_i,
    output div_pkg::div_data_t   dividend_mag_o,
    output div_pkg::div_data_t   divisor_mag_o,
    output div_pkg::div_result_t result_o
);
    import div_pkg::*;

    logic      dividend_neg;
    logic      divisor_neg;
    logic      quotient_neg;
    div_data_t quotient;
    div_data_t remainder;

    // Sign bits only matter for signed division
    assign dividend_neg = signed_i && dividend_i[`DIV_WIDTH-1];
    assign divisor_neg  = signed_i && divisor_i[`DIV_WIDTH-1];
    assign quotient_neg = dividend_neg ^ divisor_neg;

    // Two's complement magnitudes for the unsigned datapath
    // The most negative value maps onto itself, which is its correct magnitude
    assign dividend_mag_o = dividend_neg ? -dividend_i : dividend_i;
    assign divisor_mag_o  = divisor_neg ? -divisor_i : divisor_i;

    // Truncating division rules
    assign quotient  = quotient_neg ? -raw_quotient_i : raw_quotient_i;
    assign remainder = dividend_neg ? -raw_remainder_i : raw_remainder_i;

    assign result_o = {remainder, quotient};

endmodule

/* verilog/div_shift_sub.sv */
`timescale 1ns/1ps
`include "div_config.svh"

module div_shift_sub (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               load_i,
    input  logic               step_i,
    input  logic               clear_i,
    input  div_pkg::div_data_t dividend_mag_i,
    input  div_pkg::div_data_t divisor_mag_i,
    output div_pkg::div_data_t raw_quotient_o,
    output div_pkg::div_data_t raw_remainder_o
);
    import div_pkg::*;

    // Upper half is the partial remainder, lower half holds
    // the remaining dividend bits and the quotient bits shifted in
    div_result_t         work_q;
    div_result_t         work_next;
    div_data_t           divisor_q;
    logic [`DIV_WIDTH:0] partial;
    logic [`DIV_WIDTH:0] diff;
    logic                fits;

    // Shifted partial remainder needs one extra bit for large divisors
    assign partial = work_q[2*`DIV_WIDTH-1:`DIV_WIDTH-1];
    assign fits    = (partial >= {1'b0, divisor_q});
    assign diff    = partial - {1'b0, divisor_q};

    // One restoring step
    always_comb begin
        if (fits) begin
            work_next = {diff[`DIV_WIDTH-1:0], work_q[`DIV_WIDTH-2:0], 1'b1};
        end else begin
            work_next = {partial[`DIV_WIDTH-1:0], work_q[`DIV_WIDTH-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            work_q <= '0;
        end else if (load_i) begin
            work_q <= {{`DIV_WIDTH{1'b0}}, dividend_mag_i};
        end else if (step_i) begin
            work_q <= work_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            divisor_q <= divisor_mag_i;
        end
    end

    assign raw_remainder_o = work_q[2*`DIV_WIDTH-1:`DIV_WIDTH];
    assign raw_quotient_o  = work_q[`DIV_WIDTH-1:0];

    // Control must never load new operands over a step
    a_load_step_excl: assert property (
        @(posedge clk) disable iff (reset_i) !(load_i && step_i)
    ) else $error("div_shift_sub: load_i and step_i high together");

endmodule

/* verilog/div_unit.sv */
`timescale 1ns/1ps

module div_unit (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 start_i,
    input  logic                 signed_i,
    input  logic                 cancel_i,
    input  div_pkg::div_data_t   dividend_i,
    input  div_pkg::div_data_t   divisor_i,
    output div_pkg::div_result_t result_o,
    output logic                 ready_o
);
    import div_pkg::*;

    // Control to datapath
    logic load;
    logic step;
    logic clear;

    // Sign handling to and from the shift-subtract core
    div_data_t dividend_mag;
    div_data_t divisor_mag;
    div_data_t raw_quotient;
    div_data_t raw_remainder;

    div_ctrl_fsm u_div_ctrl_fsm (
        .clk       (clk),
        .reset_i   (reset_i),
        .start_i   (start_i),
        .cancel_i  (cancel_i),
        .divisor_i (divisor_i),
        .load_o    (load),
        .step_o    (step),
        .clear_o   (clear),
        .ready_o   (ready_o)
    );

    div_sign_fix u_div_sign_fix (
        .signed_i        (signed_i),
        .dividend_i      (dividend_i),
        .divisor_i       (divisor_i),
        .raw_quotient_i  (raw_quotient),
        .raw_remainder_i (raw_remainder),
        .dividend_mag_o  (dividend_mag),
        .divisor_mag_o   (divisor_mag),
        .result_o        (result_o)
    );

    div_shift_sub u_div_shift_sub (
        .clk             (clk),
        .reset_i         (reset_i),
        .load_i          (load),
        .step_i          (step),
        .clear_i         (clear),
        .dividend_mag_i  (dividend_mag),
        .divisor_mag_i   (divisor_mag),
        .raw_quotient_o  (raw_quotient),
        .raw_remainder_o (raw_remainder)
    );

endmodule

/* dv/tb_div_unit.sv */
`timescale 1ns/1ps
`include "div_config.svh"

module tb_div_unit;
    import div_pkg::*;

    // Start edge plus one edge per quotient bit
    localparam div_count_t RUN_LATENCY  = div_count_t'(`DIV_WIDTH + 1);
    localparam div_count_t ZERO_LATENCY = div_count_t'(2);
    localparam int         READY_LIMIT    = 50;
    localparam int         TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        reset_i;
    logic        start_i;
    logic        signed_i;
    logic        cancel_i;
    div_data_t   dividend_i;
    div_data_t   divisor_i;
    div_result_t result_o;
    logic        ready_o;

    int seed;
    int error_count;
    int tests_passed;
    int tests_failed;
    int cycle_count;

    div_unit u_div_unit (
        .clk        (clk),
        .reset_i    (reset_i),
        .start_i    (start_i),
        .signed_i   (signed_i),
        .cancel_i   (cancel_i),
        .dividend_i (dividend_i),
        .divisor_i  (divisor_i),
        .result_o   (result_o),
        .ready_o    (ready_o)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // Reference model with truncating division and a zero result for a zero divisor
    function automatic div_result_t expected_result(input div_data_t dividend,
                                                    input div_data_t divisor,
                                                    input logic is_signed);
        int        sa;
        int        sb;
        div_data_t q;
        div_data_t r;
        if (divisor == '0) begin
            return '0;
        end
        if (is_signed) begin
            sa = dividend;
            sb = divisor;
            q = sa / sb;
            r = sa % sb;
        end else begin
            q = dividend / divisor;
            r = dividend % divisor;
        end
        return {r, q};
    endfunction

    task automatic check_result(input string name, input div_result_t expected,
                                input div_result_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: result expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: ready expected %b, actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_latency(input string name, input div_count_t expected,
                                 input div_count_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: latency expected %0d, actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("%-16s passed", name);
        end else begin
            tests_failed++;
            $display("%-16s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // One request that keeps start high for hold_cycles extra cycles after ready
    task automatic run_division(input string name, input div_data_t dividend,
                                input div_data_t divisor, input logic is_signed,
                                input int hold_cycles);
        div_result_t expected;
        div_count_t  exp_latency;
        int          latency;
        expected    = expected_result(dividend, divisor, is_signed);
        exp_latency = (divisor == '0) ? ZERO_LATENCY : RUN_LATENCY;
        @(negedge clk);
        dividend_i = dividend;
        divisor_i  = divisor;
        signed_i   = is_signed;
        start_i    = 1'b1;
        latency    = 0;
        while (ready_o !== 1'b1 && latency < READY_LIMIT) begin
            @(posedge clk);
            latency++;
            @(negedge clk);
        end
        if (ready_o !== 1'b1) begin
            $display("%s: ready never came within %0d cycles", name, READY_LIMIT);
            error_count++;
        end else begin
            check_latency(name, exp_latency, div_count_t'(latency));
            check_result(name, expected, result_o);
            repeat (hold_cycles) begin
                @(negedge clk);
                check_ready(name, 1'b1, ready_o);
                check_result(name, expected, result_o);
            end
        end
        start_i = 1'b0;
        @(negedge clk);
        check_ready(name, 1'b0, ready_o);
    endtask

    task automatic reset_leaves_idle();
        int errors_before;
        errors_before = error_count;
        repeat (3) begin
            @(negedge clk);
            check_ready("reset", 1'b0, ready_o);
        end
        // Reach DONE and reset while start still holds the result
        @(negedge clk);
        divisor_i = '0;
        start_i   = 1'b1;
        repeat (2) @(negedge clk);
        check_ready("reset", 1'b1, ready_o);
        reset_i = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_ready("reset", 1'b0, ready_o);
        end
        start_i = 1'b0;
        reset_i = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_ready("reset", 1'b0, ready_o);
        end
        report_test("reset", errors_before);
    endtask

    task automatic unsigned_fixed_divisions();
        int errors_before;
        errors_before = error_count;
        run_division("unsigned_fixed", 32'd100, 32'd7, 1'b0, 0);
        run_division("unsigned_fixed", 32'hFFFF_FFFF, 32'd1, 1'b0, 0);
        run_division("unsigned_fixed", 32'hFFFF_FFFF, 32'h10, 1'b0, 0);
        run_division("unsigned_fixed", 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 0);
        run_division("unsigned_fixed", 32'd5, 32'd10, 1'b0, 0);
        run_division("unsigned_fixed", 32'h8000_0000, 32'd3, 1'b0, 0);
        report_test("unsigned_fixed", errors_before);
    endtask

    task automatic unsigned_random_divisions();
        int        errors_before;
        int        shift;
        div_data_t a;
        div_data_t b;
        errors_before = error_count;
        repeat (8) begin
            a     = $random(seed);
            b     = $random(seed);
            shift = {$random(seed)} % `DIV_WIDTH;
            b     = b >> shift;
            if (b == '0) begin
                b = 1;
            end
            run_division("unsigned_random", a, b, 1'b0, 0);
        end
        report_test("unsigned_random", errors_before);
    endtask

    task automatic signed_fixed_divisions();
        int errors_before;
        errors_before = error_count;
        run_division("signed_fixed", 32'd100, 32'd7, 1'b1, 0);
        run_division("signed_fixed", -32'sd100, 32'd7, 1'b1, 0);
        run_division("signed_fixed", 32'd100, -32'sd7, 1'b1, 0);
        run_division("signed_fixed", -32'sd100, -32'sd7, 1'b1, 0);
        run_division("signed_fixed", 32'h8000_0000, 32'd2, 1'b1, 0);
        run_division("signed_fixed", -32'sd3, 32'd10, 1'b1, 0);
        report_test("signed_fixed", errors_before);
    endtask

    task automatic signed_random_divisions();
        int        errors_before;
        int        shift;
        div_data_t a;
        div_data_t b;
        errors_before = error_count;
        repeat (8) begin
            a     = $random(seed);
            b     = $random(seed);
            shift = {$random(seed)} % `DIV_WIDTH;
            b     = div_data_t'($signed(b) >>> shift);
            if (b == '0) begin
                b = 1;
            end
            // Most negative over minus one overflows
            if (a == 32'h8000_0000 && b == '1) begin
                a = a + 1;
            end
            run_division("signed_random", a, b, 1'b1, 0);
        end
        report_test("signed_random", errors_before);
    endtask

    task automatic zero_divisor_requests();
        int errors_before;
        errors_before = error_count;
        run_division("zero_divisor", 32'd123, '0, 1'b0, 0);
        run_division("zero_divisor", -32'sd5, '0, 1'b1, 0);
        run_division("zero_divisor", 32'hFFFF_FFFF, '0, 1'b0, 0);
        report_test("zero_divisor", errors_before);
    endtask

    task automatic back_pressure_hold();
        int errors_before;
        errors_before = error_count;
        run_division("back_pressure", 32'd1000, 32'd33, 1'b0, 10);
        run_division("back_pressure", -32'sd77, 32'd5, 1'b1, 10);
        report_test("back_pressure", errors_before);
    endtask

    task automatic cancel_in_flight();
        int errors_before;
        errors_before = error_count;
        @(negedge clk);
        dividend_i = 32'd5000;
        divisor_i  = 32'd9;
        signed_i   = 1'b0;
        start_i    = 1'b1;
        repeat (10) @(negedge clk);
        cancel_i = 1'b1;
        start_i  = 1'b0;
        @(negedge clk);
        cancel_i = 1'b0;
        repeat (40) begin
            @(negedge clk);
            check_ready("cancel", 1'b0, ready_o);
        end
        run_division("cancel", 32'd5000, 32'd9, 1'b0, 0);
        report_test("cancel", errors_before);
    endtask

    initial begin
        seed         = 43;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count  = 0;
        reset_i      = 1'b1;
        start_i      = 1'b0;
        signed_i     = 1'b0;
        cancel_i     = 1'b0;
        dividend_i   = '0;
        divisor_i    = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        reset_leaves_idle();
        unsigned_fixed_divisions();
        unsigned_random_divisions();
        signed_fixed_divisions();
        signed_random_divisions();
        zero_divisor_requests();
        back_pressure_hold();
        cancel_in_flight();

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
verilog/div_pkg.sv
verilog/div_ctrl_fsm.sv
verilog/div_sign_fix.sv
verilog/div_shift_sub.sv
verilog/div_unit.sv
dv/tb_div_unit.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module tb_div_unit \
		-Mdir obj_dir -o Vtb_div_unit

run: build
	./obj_dir/Vtb_div_unit > sim.log 2>&1; cat sim.log
	@if grep -q "Test failures found" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi
	@grep -q "All tests passed!" sim.log || (echo "Simulation did not complete"; exit 1)

lint:
	verilator --lint-only --timing -f sim.f --top-module tb_div_unit

clean:
	rm -rf obj_dir sim.log
